// ==== sim.f ====
src/rvPkg.sv
src/instDecoder.sv
src/immGen.sv
src/regFile.sv
src/alu.sv
src/dataMem.sv
src/pcUnit.sv
src/rvCore.sv
testbench/rvCoreTb.sv

// ==== testbench/rvCoreTb.sv ====
`timescale 1ns/1ps

module rvCoreTb
    import rvPkg::*;
();

    logic clk = 1'b0;
    logic rst;
    logic [31:0] inst;
    logic [XLEN-1:0] instAddr;
    logic wbValid;
    logic [4:0] wbAddr;
    logic [XLEN-1:0] wbData;
    logic halted;

    logic [31:0] prog [1024];
    int progLen = 0;
    int cycles = 0;
    int pcErrs = 0;
    int wbErrs = 0;
    int haltErrs = 0;
    int rstErrs = 0;

    // reference model
    logic [XLEN-1:0] mPc;
    logic [XLEN-1:0] mRegs [32];
    logic [7:0] mMem [DMEM_BYTES];
    logic mHalted;
    logic expValid;
    logic [4:0] expRd;
    logic [XLEN-1:0] expData;
    logic [XLEN-1:0] expNextPc;
    logic expHalt;
    int stBytes;
    logic [XLEN-1:0] stAddr;
    logic [XLEN-1:0] stData;

    rvCore dut0 (.clk(clk), .rst(rst), .inst(inst), .instAddr(instAddr), .wbValid(wbValid),
        .wbAddr(wbAddr), .wbData(wbData), .halted(halted));

    assign inst = prog[instAddr[11:2]]; // word fetch

    always #10 clk = ~clk;

    function automatic logic [31:0] rType(int f7, int f3, int rd, int rs1, int rs2);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], opOp};
    endfunction

    function automatic logic [31:0] iType(opcodeE op, int f3, int rd, int rs1, int imm);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
    endfunction

    function automatic logic [31:0] sType(int f3, int rs1, int rs2, int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], opStore};
    endfunction

    function automatic logic [31:0] bType(int f3, int rs1, int rs2, int imm);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], opBranch};
    endfunction

    function automatic logic [31:0] uType(opcodeE op, int rd, int imm);
        return {imm[19:0], rd[4:0], op};
    endfunction

    function automatic logic [31:0] jType(int rd, int imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], opJal};
    endfunction

    task automatic emit(logic [31:0] word);
        prog[progLen] = word;
        progLen++;
    endtask

    // next state of the model from ISA rules
    always_comb begin
        logic [31:0] w;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] immI;
        logic [XLEN-1:0] raw;
        logic [2:0] f3;
        logic taken;
        w = prog[mPc[11:2]];
        f3 = w[14:12];
        a = mRegs[w[19:15]];
        b = mRegs[w[24:20]];
        immI = {{52{w[31]}}, w[31:20]};
        raw = '0;
        taken = 1'b0;
        expValid = 1'b0;
        expRd = w[11:7];
        expData = '0;
        expNextPc = mPc + 4;
        expHalt = 1'b0;
        stBytes = 0;
        stAddr = a + {{52{w[31]}}, w[31:25], w[11:7]};
        stData = b;
        case (w[6:0])
            opOp, opOpImm: begin
                if (w[6:0] == opOpImm) begin
                    b = immI;
                end
                expValid = 1'b1;
                case (f3)
                    3'd0: expData = (w[5] && w[30]) ? a - b : a + b; // sub only in R form
                    3'd1: expData = a << b[5:0];
                    3'd2: expData = ($signed(a) < $signed(b)) ? 1 : 0;
                    3'd3: expData = (a < b) ? 1 : 0;
                    3'd4: expData = a ^ b;
                    3'd5: expData = a >> b[5:0];
                    3'd6: expData = a | b;
                    default: expData = a & b;
                endcase
            end
            opLui, opAuipc: begin
                expValid = 1'b1;
                expData = {{32{w[31]}}, w[31:12], 12'h000};
                if (w[6:0] == opAuipc) begin
                    expData = expData + mPc;
                end
            end
            opLoad: begin
                expValid = 1'b1;
                for (int i = 0; i < 8; i++) begin
                    raw[8*i +: 8] = mMem[(a + immI + i) % DMEM_BYTES];
                end
                case (f3[1:0])
                    2'd0: expData = f3[2] ? 64'(raw[7:0]) : 64'($signed(raw[7:0]));
                    2'd1: expData = f3[2] ? 64'(raw[15:0]) : 64'($signed(raw[15:0]));
                    2'd2: expData = 64'($signed(raw[31:0]));
                    default: expData = raw;
                endcase
            end
            opStore: stBytes = 1 << f3[1:0];
            opBranch: begin
                case (f3)
                    3'd0: taken = (a == b);
                    3'd1: taken = (a != b);
                    3'd4: taken = ($signed(a) < $signed(b));
                    3'd5: taken = ($signed(a) >= $signed(b));
                    3'd6: taken = (a < b);
                    default: taken = (a >= b);
                endcase
                if (taken) begin
                    expNextPc = mPc + {{51{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
                end
            end
            opJal, opJalr: begin
                expValid = 1'b1;
                expData = mPc + 4;
                expNextPc = mPc + {{43{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
                if (w[6:0] == opJalr) begin
                    expNextPc = (a + immI) & ~64'd1;
                end
            end
            opSystem: begin
                expHalt = (w == 32'h0010_0073);
                expNextPc = mPc;
            end
            default: ;
        endcase
        if (mHalted) begin
            expValid = 1'b0;
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            mPc <= RESET_PC;
            mHalted <= 1'b0;
            for (int i = 0; i < 32; i++) begin
                mRegs[i] <= '0;
            end
        end else if (!mHalted) begin
            if (expValid && expRd != 5'd0) begin
                mRegs[expRd] <= expData;
            end
            for (int i = 0; i < stBytes; i++) begin
                mMem[(stAddr + i) % DMEM_BYTES] <= stData[8*i +: 8];
            end
            mPc <= expNextPc;
            mHalted <= expHalt;
        end
    end

    assert property (@(posedge clk) !rst |-> instAddr == mPc)
        else begin
            pcErrs++;
            $display("FAILED %0t: instAddr %h, model pc %h", $time,
                $sampled(instAddr), $sampled(mPc));
        end

    assert property (@(posedge clk) !rst |->
        wbValid == expValid && (!expValid || (wbAddr == expRd && wbData == expData)))
        else begin
            wbErrs++;
            $display("FAILED %0t: writeback x%0d=%h valid %b, model x%0d=%h valid %b", $time,
                $sampled(wbAddr), $sampled(wbData), $sampled(wbValid),
                $sampled(expRd), $sampled(expData), $sampled(expValid));
        end

    assert property (@(posedge clk) !rst |-> halted == mHalted)
        else begin
            haltErrs++;
            $display("FAILED %0t: halted %b, model %b", $time,
                $sampled(halted), $sampled(mHalted));
        end

    assert property (@(posedge clk) (rst && cycles > 0) |-> (!wbValid && !halted))
        else begin
            rstErrs++;
            $display("FAILED %0t: wbValid or halted high during reset", $time);
        end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > progLen + 55) begin // 5 reset cycles on top
            $display("timeout: the core never halted within %0d cycles", cycles);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    initial begin
        int n;
        int kind;
        int f;
        int rd;
        int rs;
        int imm;
        rst = 1'b1;
        void'($urandom(14637));
        emit(iType(opOpImm, 0, 1, 0, -5));
        emit(iType(opOpImm, 0, 2, 0, 3));
        emit(iType(opOpImm, 0, 0, 1, 77)); // x0 stays zero
        emit(rType(0, 0, 3, 0, 2));
        emit(rType(32, 0, 4, 2, 1));
        for (f = 0; f < 8; f++) begin
            emit(rType(0, f, 5 + f, 1, 2));
            emit(iType(opOpImm, f, 13 + f, 1, (f == 1 || f == 5) ? 35 : -300));
        end
        emit(uType(opLui, 6, 32'h8F0E1));
        emit(uType(opAuipc, 21, 32'hFFFFF));
        emit(iType(opOpImm, 0, 6, 6, -22));
        emit(iType(opOpImm, 1, 7, 6, 32));
        emit(rType(0, 4, 7, 7, 6)); // sign bits differ per byte
        emit(iType(opOpImm, 0, 20, 0, 256)); // data base
        for (n = 0; n < 4; n++) begin
            emit(sType(3 - n, 20, 7, 8 * n)); // sd sw sh sb
        end
        // loads stay inside stored bytes
        for (f = 0; f < 6; f++) begin
            for (rs = 0; rs < 4; rs++) begin
                n = 1 << (f % 4);
                if (n <= (8 >> rs)) begin
                    emit(iType(opLoad, f, 8 + progLen % 8, 20, 8 * rs + (8 >> rs) - n));
                end
            end
        end
        for (f = 0; f < 8; f++) begin
            for (n = 0; n < 3 && f != 2 && f != 3; n++) begin
                emit(bType(f, (n == 1) ? 2 : 1, (n == 0) ? 2 : 1, 8));
                emit(iType(opOpImm, 0, 31, 31, 1)); // skipped when taken
            end
        end
        emit(iType(opOpImm, 0, 3, 0, 3));
        emit(iType(opOpImm, 0, 3, 3, -1));
        emit(bType(1, 3, 0, -4)); // backward loop
        emit(jType(1, 8));
        emit(iType(opOpImm, 0, 31, 31, 1));
        emit(uType(opAuipc, 8, 0));
        emit(iType(opJalr, 0, 9, 8, 13)); // odd target
        emit(iType(opOpImm, 0, 31, 31, 1));
        for (int i = 0; i < 40; i++) begin
            kind = $urandom % 4;
            f = $urandom % 8;
            rd = $urandom % 16;
            rs = $urandom % 16;
            imm = (f == 1 || f == 5) ? $urandom % 64 : $urandom % 4096;
            case (kind)
                0: emit(rType((f == 0 && imm[0]) ? 32 : 0, f, rd, rs, imm % 16));
                1: emit(iType(opOpImm, f, rd, rs, imm));
                2: emit(uType(opLui, rd, $urandom));
                default: emit(uType(opAuipc, rd, $urandom));
            endcase
        end
        emit(32'h0010_0073); // ebreak
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        wait (halted === 1'b1);
        repeat (10) @(posedge clk);
        $display("errors: pc %0d, writeback %0d, halt %0d, reset %0d",
            pcErrs, wbErrs, haltErrs, rstErrs);
        if (pcErrs + wbErrs + haltErrs + rstErrs == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// ==== src/rvCore.sv ====
`timescale 1ns/1ps

module rvCore
    import rvPkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic [31:0]     inst,
    output logic [XLEN-1:0] instAddr,
    output logic            wbValid,
    output logic [4:0]      wbAddr,
    output logic [XLEN-1:0] wbData,
    output logic            halted
);

    ctrlT ctrl;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] pcPlus4;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] rs1Data;
    logic [XLEN-1:0] rs2Data;
    logic [XLEN-1:0] opA;
    logic [XLEN-1:0] opB;
    logic [XLEN-1:0] aluResult;
    logic [XLEN-1:0] memData;
    logic [XLEN-1:0] loadData;
    logic commitOk;
    logic regWrite;

    assign commitOk = !halted && !rst; // no state change once halted
    assign regWrite = ctrl.writeRd && commitOk;

    assign opA = ctrl.selA ? rs1Data : pc;
    assign opB = ctrl.selB ? rs2Data : imm;
    assign loadData = ctrl.memRead ? memData : '0;

    always_comb begin
        case (ctrl.wbSel)
            wbMem:     wbData = loadData;
            wbPcPlus4: wbData = pcPlus4;
            default:   wbData = aluResult;
        endcase
    end

    assign instAddr = pc;
    assign wbAddr = inst[11:7];
    assign wbValid = regWrite;

    pcUnit pcUnit0 (.clk(clk), .rst(rst), .takeJump(ctrl.takeJump),
        .jumpReg(ctrl.jumpReg), .isEbreak(ctrl.isEbreak), .imm(imm),
        .jumpBase(aluResult), .pc(pc), .pcPlus4(pcPlus4), .halted(halted));

    instDecoder instDecoder0 (.inst(inst), .rs1Data(rs1Data), .rs2Data(rs2Data),
        .ctrl(ctrl));

    immGen immGen0 (.inst(inst), .imm(imm));

    regFile regFile0 (.clk(clk), .rst(rst), .rs1Addr(inst[19:15]),
        .rs2Addr(inst[24:20]), .rdAddr(wbAddr), .rdData(wbData),
        .writeEn(regWrite), .rs1Data(rs1Data), .rs2Data(rs2Data));

    alu alu0 (.op(ctrl.aluOp), .a(opA), .b(opB), .result(aluResult));

    dataMem dataMem0 (.clk(clk), .addr(aluResult), .writeData(rs2Data),
        .writeMask(ctrl.memWriteMask), .writeEn(commitOk),
        .readNum(ctrl.readNum), .loadSigned(ctrl.loadSigned), .readData(memData));

endmodule

// ==== src/pcUnit.sv ====
`timescale 1ns/1ps

module pcUnit
    import rvPkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic            takeJump,
    input  logic            jumpReg,
    input  logic            isEbreak,
    input  logic [XLEN-1:0] imm,
    input  logic [XLEN-1:0] jumpBase,
    output logic [XLEN-1:0] pc,
    output logic [XLEN-1:0] pcPlus4,
    output logic            halted
);

    logic [XLEN-1:0] nextPc;

    assign pcPlus4 = pc + 64'd4;

    always_comb begin
        if (isEbreak) begin
            nextPc = pc; // park on the ebreak
        end else if (takeJump && jumpReg) begin
            nextPc = {jumpBase[XLEN-1:1], 1'b0};
        end else if (takeJump) begin
            nextPc = pc + imm;
        end else begin
            nextPc = pcPlus4;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= RESET_PC;
            halted <= 1'b0;
        end else if (!halted) begin
            pc <= nextPc;
            halted <= isEbreak;
        end
    end

endmodule

// ==== src/dataMem.sv ====
`timescale 1ns/1ps

module dataMem
    import rvPkg::*;
(
    input  logic            clk,
    input  logic [XLEN-1:0] addr,
    input  logic [XLEN-1:0] writeData,
    input  logic [7:0]      writeMask,
    input  logic            writeEn,
    input  logic [3:0]      readNum,
    input  logic            loadSigned,
    output logic [XLEN-1:0] readData
);

    logic [7:0] mem [DMEM_BYTES];
    logic [DMEM_AW-1:0] base;
    logic [XLEN-1:0] raw;

    assign base = addr[DMEM_AW-1:0]; // wraps modulo size

    always_ff @(posedge clk) begin
        if (writeEn) begin
            for (int i = 0; i < 8; i++) begin
                if (writeMask[i]) begin
                    mem[DMEM_AW'(base + i)] <= writeData[8*i +: 8];
                end
            end
        end
    end

    // little-endian gather of 8 bytes
    always_comb begin
        for (int i = 0; i < 8; i++) begin
            raw[8*i +: 8] = mem[DMEM_AW'(base + i)];
        end
    end

    always_comb begin
        case (readNum)
            4'h1: begin
                readData = {{(XLEN-8){loadSigned & raw[7]}}, raw[7:0]};
            end
            4'h2: begin
                readData = {{(XLEN-16){loadSigned & raw[15]}}, raw[15:0]};
            end
            4'h4: begin
                readData = {{(XLEN-32){loadSigned & raw[31]}}, raw[31:0]};
            end
            4'h8: begin
                readData = raw;
            end
            default: begin
                readData = '0;
            end
        endcase
    end

endmodule

// ==== src/alu.sv ====
`timescale 1ns/1ps

module alu
    import rvPkg::*;
(
    input  aluOpE           op,
    input  logic [XLEN-1:0] a,
    input  logic [XLEN-1:0] b,
    output logic [XLEN-1:0] result
);

    logic [5:0] shamt;

    assign shamt = b[5:0]; // rv64 shift range

    always_comb begin
        case (op)
            aluAdd:   result = a + b;
            aluSub:   result = a - b;
            aluXor:   result = a ^ b;
            aluOr:    result = a | b;
            aluAnd:   result = a & b;
            aluSll:   result = a << shamt;
            aluSrl:   result = a >> shamt;
            aluSlt: begin
                result = {{(XLEN-1){1'b0}}, ($signed(a) < $signed(b))};
            end
            aluSltu: begin
                result = {{(XLEN-1){1'b0}}, (a < b)};
            end
            aluPassB: result = b;
            default:  result = '0;
        endcase
    end

endmodule

// ==== src/regFile.sv ====
`timescale 1ns/1ps

module regFile
    import rvPkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic [4:0]      rs1Addr,
    input  logic [4:0]      rs2Addr,
    input  logic [4:0]      rdAddr,
    input  logic [XLEN-1:0] rdData,
    input  logic            writeEn,
    output logic [XLEN-1:0] rs1Data,
    output logic [XLEN-1:0] rs2Data
);

    logic [XLEN-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn && rdAddr != 5'd0) begin
            regs[rdAddr] <= rdData;
        end
    end

    // x0 reads zero
    assign rs1Data = (rs1Addr == 5'd0) ? '0 : regs[rs1Addr];
    assign rs2Data = (rs2Addr == 5'd0) ? '0 : regs[rs2Addr];

endmodule

// ==== src/immGen.sv ====
`timescale 1ns/1ps

module immGen
    import rvPkg::*;
(
    input  logic [31:0]     inst,
    output logic [XLEN-1:0] imm
);

    opcodeE opcode;

    assign opcode = opcodeE'(inst[6:0]);

    always_comb begin
        case (opcode)
            opOpImm, opLoad, opJalr: begin
                imm = {{(XLEN-12){inst[31]}}, inst[31:20]};
            end
            opStore: begin
                imm = {{(XLEN-12){inst[31]}}, inst[31:25], inst[11:7]};
            end
            opBranch: begin
                imm = {{(XLEN-13){inst[31]}}, inst[31], inst[7], inst[30:25],
                       inst[11:8], 1'b0};
            end
            opLui, opAuipc: begin
                imm = {{(XLEN-32){inst[31]}}, inst[31:12], 12'h000};
            end
            opJal: begin
                imm = {{(XLEN-21){inst[31]}}, inst[31], inst[19:12], inst[20],
                       inst[30:21], 1'b0};
            end
            default: begin
                imm = '0; // r-type and system carry none
            end
        endcase
    end

endmodule

// ==== src/instDecoder.sv ====
`timescale 1ns/1ps

module instDecoder
    import rvPkg::*;
(
    input  logic [31:0]     inst,
    input  logic [XLEN-1:0] rs1Data,
    input  logic [XLEN-1:0] rs2Data,
    output ctrlT            ctrl
);

    opcodeE opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = opcodeE'(inst[6:0]);
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    always_comb begin
        ctrl = '0;
        ctrl.aluOp = aluNone;
        ctrl.wbSel = wbAlu;
        case (opcode)
            opOp: begin
                ctrl.selA = 1'b1;
                ctrl.selB = 1'b1;
                if (funct7 == 7'h00) begin
                    case (funct3)
                        3'b000: ctrl.aluOp = aluAdd;
                        3'b001: ctrl.aluOp = aluSll;
                        3'b010: ctrl.aluOp = aluSlt;
                        3'b011: ctrl.aluOp = aluSltu;
                        3'b100: ctrl.aluOp = aluXor;
                        3'b101: ctrl.aluOp = aluSrl;
                        3'b110: ctrl.aluOp = aluOr;
                        default: ctrl.aluOp = aluAnd;
                    endcase
                end else if (funct7 == 7'h20 && funct3 == 3'b000) begin
                    ctrl.aluOp = aluSub;
                end
                ctrl.writeRd = (ctrl.aluOp != aluNone);
            end
            opOpImm: begin
                ctrl.selA = 1'b1;
                case (funct3)
                    3'b000: ctrl.aluOp = aluAdd;
                    3'b010: ctrl.aluOp = aluSlt;
                    3'b011: ctrl.aluOp = aluSltu;
                    3'b100: ctrl.aluOp = aluXor;
                    3'b110: ctrl.aluOp = aluOr;
                    3'b111: ctrl.aluOp = aluAnd;
                    // rv64 shamt is 6 bits so funct6 must be zero
                    3'b001: ctrl.aluOp = (inst[31:26] == 6'h00) ? aluSll : aluNone;
                    default: ctrl.aluOp = (inst[31:26] == 6'h00) ? aluSrl : aluNone;
                endcase
                ctrl.writeRd = (ctrl.aluOp != aluNone);
            end
            opAuipc: begin
                ctrl.aluOp = aluAdd; // pc + imm
                ctrl.writeRd = 1'b1;
            end
            opLui: begin
                ctrl.aluOp = aluPassB;
                ctrl.writeRd = 1'b1;
            end
            opLoad: begin
                ctrl.selA = 1'b1;
                ctrl.aluOp = aluAdd;
                ctrl.wbSel = wbMem;
                case (funct3)
                    3'h0: ctrl.readNum = 4'h1;
                    3'h1: ctrl.readNum = 4'h2;
                    3'h2: ctrl.readNum = 4'h4;
                    3'h3: ctrl.readNum = 4'h8;
                    3'h4: ctrl.readNum = 4'h1;
                    3'h5: ctrl.readNum = 4'h2;
                    default: ctrl.readNum = 4'h0; // lwu not supported
                endcase
                ctrl.loadSigned = ~funct3[2];
                ctrl.memRead = (ctrl.readNum != 4'h0);
                ctrl.writeRd = ctrl.memRead;
            end
            opStore: begin
                ctrl.selA = 1'b1;
                ctrl.aluOp = aluAdd; // address is rs1 + imm
                case (funct3)
                    3'b000: ctrl.memWriteMask = 8'b0000_0001;
                    3'b001: ctrl.memWriteMask = 8'b0000_0011;
                    3'b010: ctrl.memWriteMask = 8'b0000_1111;
                    3'b011: ctrl.memWriteMask = 8'b1111_1111;
                    default: ctrl.memWriteMask = 8'b0;
                endcase
            end
            opJal: begin
                ctrl.writeRd = 1'b1;
                ctrl.wbSel = wbPcPlus4;
                ctrl.takeJump = 1'b1;
            end
            opJalr: begin
                if (funct3 == 3'b000) begin
                    ctrl.selA = 1'b1;
                    ctrl.aluOp = aluAdd;
                    ctrl.writeRd = 1'b1;
                    ctrl.wbSel = wbPcPlus4;
                    ctrl.jumpReg = 1'b1;
                    ctrl.takeJump = 1'b1;
                end
            end
            opBranch: begin
                case (funct3)
                    3'h0: ctrl.takeJump = (rs1Data == rs2Data);
                    3'h1: ctrl.takeJump = (rs1Data != rs2Data);
                    3'h4: ctrl.takeJump = ($signed(rs1Data) < $signed(rs2Data));
                    3'h5: ctrl.takeJump = ($signed(rs1Data) >= $signed(rs2Data));
                    3'h6: ctrl.takeJump = (rs1Data < rs2Data);
                    3'h7: ctrl.takeJump = (rs1Data >= rs2Data);
                    default: ctrl.takeJump = 1'b0;
                endcase
            end
            opSystem: begin
                ctrl.isEbreak = (inst == 32'h0010_0073);
            end
            default: ; // unknown encoding leaves everything off
        endcase
    end

endmodule

// ==== src/rvPkg.sv ====
package rvPkg;

    localparam int XLEN = 64;
    localparam logic [XLEN-1:0] RESET_PC = '0;
    localparam int DMEM_BYTES = 4096;
    localparam int DMEM_AW = $clog2(DMEM_BYTES);

    // RV64I major opcodes, inst[6:0]
    typedef enum logic [6:0] {
        opOp     = 7'b0110011,
        opOpImm  = 7'b0010011,
        opAuipc  = 7'b0010111,
        opLui    = 7'b0110111,
        opLoad   = 7'b0000011,
        opStore  = 7'b0100011,
        opJal    = 7'b1101111,
        opJalr   = 7'b1100111,
        opBranch = 7'b1100011,
        opSystem = 7'b1110011
    } opcodeE;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluXor,
        aluOr,
        aluAnd,
        aluSll,
        aluSrl,
        aluSlt,
        aluSltu,
        aluPassB, // lui
        aluNone   // result is zero
    } aluOpE;

    typedef enum logic [1:0] {
        wbAlu,
        wbMem,
        wbPcPlus4
    } wbSelE;

    typedef struct packed {
        aluOpE       aluOp;
        logic        selA;         // 1 rs1, 0 pc
        logic        selB;         // 1 rs2, 0 imm
        logic        writeRd;
        wbSelE       wbSel;
        logic        memRead;
        logic [7:0]  memWriteMask;
        logic        loadSigned;
        logic [3:0]  readNum;      // bytes
        logic        jumpReg;      // target from rs1 + imm
        logic        takeJump;
        logic        isEbreak;
    } ctrlT;

endpackage
